// File: filelist.f
+incdir+include
design/fir_types_pkg.sv
design/fir_regs_pkg.sv
design/fir_result_if.sv
design/stream_fifo.sv
design/fir_cfg_regs.sv
design/fir_datapath.sv
design/fir_out_port.sv
design/fir_filter_top.sv
verif/fir_tb.sv

// File: Bender.yml
package:
  name: fir_filter

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/fir_types_pkg.sv
      - design/fir_regs_pkg.sv
      - design/fir_result_if.sv
      - design/stream_fifo.sv
      - design/fir_cfg_regs.sv
      - design/fir_datapath.sv
      - design/fir_out_port.sv
      - design/fir_filter_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verif/fir_tb.sv

// File: verif/fir_tb.sv
// Testbench for the streaming FIR filter: clock, reset, credit-aware driver,
// reference model, output monitor and the directed and random tests
`timescale 1ns/10ps
`include "fir_defines.svh"

module fir_tb;
    import fir_types_pkg::*;
    import fir_regs_pkg::*;

    localparam int          TIMEOUT_CYCLES = 500;
    localparam logic [63:0] SEED           = `FIR_COEFF_SEED;
    localparam longint      MAX_VAL        = (longint'(1) << (`FIR_SAMPLE_W - 1)) - 1;
    localparam longint      MIN_VAL        = -MAX_VAL - 1;

    logic        clk;
    logic        rst;
    logic        in_valid;
    sample_t     in_data;
    logic        in_credit;
    logic        out_valid;
    sample_t     out_data;
    logic        out_sat;
    logic        out_credit;
    logic        cfg_we;
    cfg_addr_t   cfg_addr;
    logic [15:0] cfg_wdata;
    logic [15:0] cfg_rdata;

    // Model registers and delay line
    int      m_taps [`FIR_NUM_TAPS];
    int      m_coeffs [`FIR_NUM_TAPS];
    int      m_shift;
    logic    m_enable;

    result_t exp_q [$];
    int      up_credits      = `FIR_IN_DEPTH;
    int      ds_credits      = `FIR_OUT_CREDITS;
    int      pending_returns = 0;
    int      sent_count      = 0;
    int      credit_pulses   = 0;
    int      out_count       = 0;
    logic    hold_credits;
    int      seed            = 32'ha984;

    fir_filter_top u_fir_filter_top (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_sat    (out_sat),
        .out_credit (out_credit),
        .cfg_we     (cfg_we),
        .cfg_addr   (cfg_addr),
        .cfg_wdata  (cfg_wdata),
        .cfg_rdata  (cfg_rdata)
    );

    always #10 clk = ~clk;

    task automatic abort_run();
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic fail_with(input string what);
        $display("Error at %0t: %s", $time, what);
        abort_run();
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected !== actual) begin
            $display("[FAIL] time=%0t %s expected=%0d actual=%0d", $time, name, expected, actual);
            abort_run();
        end
    endtask

    // Shift the model delay line, then apply the filter rule
    function automatic result_t ref_filter(input sample_t s);
        longint  acc;
        longint  shifted;
        result_t r;
        for (int j = `FIR_NUM_TAPS - 1; j > 0; j--) begin
            m_taps[j] = m_taps[j-1];
        end
        m_taps[0] = int'(s);
        acc = 0;
        for (int j = 0; j < `FIR_NUM_TAPS; j++) begin
            acc = acc + longint'(m_taps[j]) * longint'(m_coeffs[j]);
        end
        shifted = acc >>> m_shift;
        if (shifted > MAX_VAL) begin
            r = '{value: sample_t'(MAX_VAL), sat: 1'b1};
        end else if (shifted < MIN_VAL) begin
            r = '{value: sample_t'(MIN_VAL), sat: 1'b1};
        end else begin
            r = '{value: sample_t'(shifted), sat: 1'b0};
        end
        return r;
    endfunction

    task automatic write_reg(input cfg_addr_t addr, input logic [15:0] data);
        @(posedge clk);
        #2;
        cfg_we    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        if (addr == FIR_REG_CTRL) begin
            m_enable = data[0];
            m_shift  = int'(data[4:1]);
        end else begin
            m_coeffs[addr - FIR_REG_COEFF0] = int'($signed(data));
        end
        @(posedge clk);
        #2;
        cfg_we = 1'b0;
    endtask

    task automatic read_reg(input cfg_addr_t addr, input int expected);
        @(posedge clk);
        #2;
        cfg_addr = addr;
        @(posedge clk);
        #2;
        check_value("cfg_rdata", expected, int'(cfg_rdata));
    endtask

    // Holds in_valid across calls so samples can go back to back
    task automatic send_sample(input sample_t s);
        int waited;
        waited = 0;
        @(posedge clk);
        #2;
        while (up_credits == 0) begin
            in_valid = 1'b0;
            waited++;
            if (waited > TIMEOUT_CYCLES) begin
                fail_with("timeout waiting for an upstream credit");
            end
            @(posedge clk);
            #2;
        end
        in_valid = 1'b1;
        in_data  = s;
        up_credits--;
        sent_count++;
        exp_q.push_back(ref_filter(s));
    endtask

    task automatic end_burst();
        @(posedge clk);
        #2;
        in_valid = 1'b0;
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 || pending_returns != 0) begin
            @(posedge clk);
            waited++;
            if (waited > TIMEOUT_CYCLES) begin
                fail_with("timeout waiting for all expected results");
            end
        end
    endtask

    task automatic wait_outputs(input int target);
        int waited;
        waited = 0;
        while (out_count < target) begin
            @(posedge clk);
            waited++;
            if (waited > TIMEOUT_CYCLES) begin
                fail_with("timeout waiting for output results");
            end
        end
    endtask

    // Output monitor and credit bookkeeping, sampled mid-cycle
    always @(negedge clk) begin
        if (in_credit === 1'b1) begin
            credit_pulses++;
            up_credits++;
        end
        if (out_valid === 1'b1) begin
            if (ds_credits == 0) begin
                fail_with("out_valid without a downstream credit granted");
            end
            if (exp_q.size() == 0) begin
                fail_with("out_valid with no result expected");
            end
            ds_credits--;
            out_count++;
            pending_returns++;
            check_value("out_data", int'(exp_q[0].value), int'(out_data));
            check_value("out_sat", int'(exp_q[0].sat), int'(out_sat));
            void'(exp_q.pop_front());
        end
    end

    // Downstream hands back one credit per consumed result
    always @(posedge clk) begin
        #2;
        if (!hold_credits && pending_returns > 0) begin
            out_credit = 1'b1;
            pending_returns--;
            ds_credits++;
        end else begin
            out_credit = 1'b0;
        end
    end

    initial begin
        int          base_out;
        int          base_pulses;
        logic [31:0] r;
        logic [15:0] c;
        clk          = 1'b0;
        rst          = 1'b1;
        in_valid     = 1'b0;
        in_data      = '0;
        out_credit   = 1'b0;
        cfg_we       = 1'b0;
        cfg_addr     = '0;
        cfg_wdata    = '0;
        hold_credits = 1'b0;
        m_enable     = 1'b1;
        m_shift      = 0;
        for (int j = 0; j < `FIR_NUM_TAPS; j++) begin
            c           = SEED[15:0] + 16'(j);
            m_coeffs[j] = int'($signed(c));
            m_taps[j]   = 0;
        end
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;

        // Reset readback and impulse response
        read_reg(FIR_REG_CTRL, int'({m_shift[3:0], m_enable}));
        for (int j = 0; j < `FIR_NUM_TAPS; j++) begin
            read_reg(cfg_addr_t'(FIR_REG_COEFF0 + j), m_coeffs[j] & 32'hffff);
        end
        send_sample(16'sd1);
        for (int j = 1; j < `FIR_NUM_TAPS; j++) begin
            send_sample(16'sd0);
        end
        end_burst();
        wait_idle();

        // Random coefficients and samples with a shift
        for (int j = 0; j < `FIR_NUM_TAPS; j++) begin
            r = $random(seed);
            write_reg(cfg_addr_t'(FIR_REG_COEFF0 + j), r[15:0]);
        end
        write_reg(FIR_REG_CTRL, {11'd0, 4'd13, 1'b1});
        read_reg(cfg_addr_t'(FIR_REG_COEFF0 + 2), m_coeffs[2] & 32'hffff);
        for (int i = 0; i < 24; i++) begin
            r = $random(seed);
            send_sample(sample_t'(r[15:0]));
        end
        end_burst();
        wait_idle();

        // Saturation at both limits
        for (int j = 0; j < `FIR_NUM_TAPS; j++) begin
            write_reg(cfg_addr_t'(FIR_REG_COEFF0 + j), 16'h7fff);
        end
        write_reg(FIR_REG_CTRL, 16'h0001);
        for (int i = 0; i < 4; i++) begin
            send_sample(16'sh7fff);
        end
        for (int i = 0; i < 6; i++) begin
            send_sample(16'sh8000);
        end
        end_burst();
        wait_idle();

        // Downstream withholds credits
        @(negedge clk);
        hold_credits = 1'b1;
        base_out     = out_count;
        for (int i = 0; i < 8; i++) begin
            send_sample(sample_t'(16'sd300 * i - 16'sd1000));
        end
        end_burst();
        wait_outputs(base_out + `FIR_OUT_CREDITS);
        repeat (30) @(posedge clk);
        check_value("out_valid count while held", base_out + `FIR_OUT_CREDITS, out_count);
        @(negedge clk);
        hold_credits = 1'b0;
        wait_idle();

        // Disabled filter keeps its samples queued
        write_reg(FIR_REG_CTRL, 16'h0000);
        for (int i = 0; i < 3; i++) begin
            send_sample(sample_t'(16'sd7 + 16'sd5 * i));
        end
        end_burst();
        base_out    = out_count;
        base_pulses = credit_pulses;
        repeat (20) @(posedge clk);
        check_value("out_valid count while disabled", base_out, out_count);
        check_value("in_credit count while disabled", base_pulses, credit_pulses);
        write_reg(FIR_REG_CTRL, 16'h0001);
        wait_idle();

        check_value("in_credit pulses", sent_count, credit_pulses);
        if (exp_q.size() != 0) begin
            fail_with("expected results left over at the end");
        end else begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule

// File: design/fir_filter_top.sv
// Top level of the streaming FIR filter: input queue, configuration registers,
// datapath and credit-controlled output port
`timescale 1ns/10ps
`include "fir_defines.svh"

module fir_filter_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    in_valid,
    input  fir_types_pkg::sample_t  in_data,
    output logic                    in_credit,
    output logic                    out_valid,
    output fir_types_pkg::sample_t  out_data,
    output logic                    out_sat,
    input  logic                    out_credit,
    input  logic                    cfg_we,
    input  fir_regs_pkg::cfg_addr_t cfg_addr,
    input  logic [15:0]             cfg_wdata,
    output logic [15:0]             cfg_rdata
);
    import fir_types_pkg::*;
    import fir_regs_pkg::*;

    sample_t      fifo_data;
    logic         fifo_empty;
    logic         fifo_full;
    logic         fifo_pop;
    ctrl_reg_t    ctrl;
    coeff_array_t coeffs;

    fir_result_if u_res_if ();

    // Upstream credits cover every slot, so in_valid always finds room
    stream_fifo #(
        .payload_t (sample_t),
        .DEPTH     (`FIR_IN_DEPTH)
    ) u_in_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (in_valid),
        .push_data (in_data),
        .pop       (fifo_pop),
        .pop_data  (fifo_data),
        .empty     (fifo_empty),
        .full      (fifo_full)
    );

    fir_cfg_regs u_cfg_regs (
        .clk       (clk),
        .rst       (rst),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata),
        .ctrl      (ctrl),
        .coeffs    (coeffs)
    );

    fir_datapath u_datapath (
        .clk        (clk),
        .rst        (rst),
        .fifo_empty (fifo_empty),
        .fifo_pop   (fifo_pop),
        .fifo_data  (fifo_data),
        .ctrl       (ctrl),
        .coeffs     (coeffs),
        .res        (u_res_if.src)
    );

    fir_out_port u_out_port (
        .clk        (clk),
        .rst        (rst),
        .res        (u_res_if.dst),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_sat    (out_sat),
        .out_credit (out_credit)
    );

    // Each freed input slot goes back upstream one cycle later
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            in_credit <= 1'b0;
        end else begin
            in_credit <= fifo_pop;
        end
    end

    a_in_credit_respected: assert property (
        @(posedge clk) disable iff (rst) in_valid |-> !fifo_full
    ) else $error("fir_filter_top: in_valid with no upstream credit");

endmodule

// File: design/fir_out_port.sv
// Result queue and downstream credit counter for the FIR output port
`timescale 1ns/10ps
`include "fir_defines.svh"

module fir_out_port (
    input  logic                   clk,
    input  logic                   rst,
    fir_result_if.dst              res,
    output logic                   out_valid,
    output fir_types_pkg::sample_t out_data,
    output logic                   out_sat,
    input  logic                   out_credit
);
    import fir_types_pkg::*;

    localparam int CRED_W = $clog2(`FIR_OUT_CREDITS + 1);

    result_t           q_in;
    result_t           q_out;
    logic              q_empty;
    logic              q_full;
    logic              drain;
    logic [CRED_W-1:0] credits;

    assign q_in = '{value: res.result, sat: res.sat};

    // Datapath credits keep this queue from overflowing
    stream_fifo #(
        .payload_t (result_t),
        .DEPTH     (`FIR_RES_DEPTH)
    ) u_res_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (res.valid),
        .push_data (q_in),
        .pop       (drain),
        .pop_data  (q_out),
        .empty     (q_empty),
        .full      (q_full)
    );

    assign drain    = !q_empty && (credits != '0);
    assign res.free = drain;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
            credits   <= CRED_W'(`FIR_OUT_CREDITS);
        end else begin
            out_valid <= drain;
            case ({drain, out_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        out_data <= q_out.value;
        out_sat  <= q_out.sat;
    end

    // Downstream returns no more credits than it was granted
    a_out_cred_bound: assert property (
        @(posedge clk) disable iff (rst) credits <= CRED_W'(`FIR_OUT_CREDITS)
    ) else $error("fir_out_port: downstream credit count %0d above its grant", credits);

    a_res_no_overflow: assert property (
        @(posedge clk) disable iff (rst) res.valid |-> !q_full
    ) else $error("fir_out_port: result arrived with the result queue full");

endmodule

// File: design/fir_datapath.sv
// FIR delay line, registered multiply stage, sum with shift and saturation,
// and the credit count that guards the result queue
`timescale 1ns/10ps
`include "fir_defines.svh"

module fir_datapath (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        fifo_empty,
    output logic                        fifo_pop,
    input  fir_types_pkg::sample_t      fifo_data,
    input  fir_regs_pkg::ctrl_reg_t     ctrl,
    input  fir_types_pkg::coeff_array_t coeffs,
    fir_result_if.src                   res
);
    import fir_types_pkg::*;

    localparam int   CRED_W  = $clog2(`FIR_RES_DEPTH + 1);
    localparam acc_t SAT_MAX = (acc_t'(1) <<< (`FIR_SAMPLE_W - 1)) - acc_t'(1);
    localparam acc_t SAT_MIN = -SAT_MAX - acc_t'(1);

    sample_t           taps [`FIR_NUM_TAPS];
    prod_t             prods [`FIR_NUM_TAPS];
    logic              tap_vld;
    logic              prod_vld;
    logic [CRED_W-1:0] cred_cnt;
    acc_t              sum;
    acc_t              shifted;

    // Pop only when a result slot is guaranteed downstream
    assign fifo_pop = ctrl.enable && !fifo_empty && (cred_cnt != '0);

    // Delay line, newest sample in taps[0]
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int k = 0; k < `FIR_NUM_TAPS; k++) begin
                taps[k] <= '0;
            end
        end else if (fifo_pop) begin
            taps[0] <= fifo_data;
            for (int k = 1; k < `FIR_NUM_TAPS; k++) begin
                taps[k] <= taps[k-1];
            end
        end
    end

    // Product stage
    always_ff @(posedge clk) begin
        for (int k = 0; k < `FIR_NUM_TAPS; k++) begin
            prods[k] <= taps[k] * coeffs[k];
        end
    end

    // Sum in full precision, then arithmetic shift
    always_comb begin
        sum = '0;
        for (int k = 0; k < `FIR_NUM_TAPS; k++) begin
            sum = sum + acc_t'(prods[k]);
        end
        shifted = sum >>> ctrl.shift;
    end

    // Clamp to the sample range
    always_ff @(posedge clk) begin
        if (shifted > SAT_MAX) begin
            res.result <= sample_t'(SAT_MAX);
            res.sat    <= 1'b1;
        end else if (shifted < SAT_MIN) begin
            res.result <= sample_t'(SAT_MIN);
            res.sat    <= 1'b1;
        end else begin
            res.result <= sample_t'(shifted);
            res.sat    <= 1'b0;
        end
    end

    // Valid follows the sample through both stages
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tap_vld   <= 1'b0;
            prod_vld  <= 1'b0;
            res.valid <= 1'b0;
        end else begin
            tap_vld   <= fifo_pop;
            prod_vld  <= tap_vld;
            res.valid <= prod_vld;
        end
    end

    // One credit per free result queue slot
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cred_cnt <= CRED_W'(`FIR_RES_DEPTH);
        end else begin
            case ({fifo_pop, res.free})
                2'b10:   cred_cnt <= cred_cnt - 1'b1;
                2'b01:   cred_cnt <= cred_cnt + 1'b1;
                default: cred_cnt <= cred_cnt;
            endcase
        end
    end

    // Free pulses from the output port must match earlier issues
    a_cred_bound: assert property (
        @(posedge clk) disable iff (rst) cred_cnt <= CRED_W'(`FIR_RES_DEPTH)
    ) else $error("fir_datapath: credit count %0d above result depth", cred_cnt);

endmodule

// File: design/fir_cfg_regs.sv
// Configuration registers for the FIR filter: enable, shift and coefficients
`timescale 1ns/10ps
`include "fir_defines.svh"

module fir_cfg_regs (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        cfg_we,
    input  fir_regs_pkg::cfg_addr_t     cfg_addr,
    input  logic [15:0]                 cfg_wdata,
    output logic [15:0]                 cfg_rdata,
    output fir_regs_pkg::ctrl_reg_t     ctrl,
    output fir_types_pkg::coeff_array_t coeffs
);
    import fir_regs_pkg::*;
    import fir_types_pkg::*;

    localparam logic [63:0] SEED = `FIR_COEFF_SEED;

    logic [15:0] rdata_next;

    // Register writes, coefficients seeded at reset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ctrl <= CTRL_RESET;
            for (int j = 0; j < `FIR_NUM_TAPS; j++) begin
                coeffs[j] <= coeff_t'(SEED[15:0] + 16'(j));
            end
        end else if (cfg_we) begin
            if (cfg_addr == FIR_REG_CTRL) begin
                ctrl <= ctrl_reg_t'(cfg_wdata[$bits(ctrl_reg_t)-1:0]);
            end
            for (int j = 0; j < `FIR_NUM_TAPS; j++) begin
                if (cfg_addr == cfg_addr_t'(FIR_REG_COEFF0 + j)) begin
                    coeffs[j] <= coeff_t'(cfg_wdata);
                end
            end
        end
    end

    // Readback mux, unmapped addresses read as zero
    always_comb begin
        rdata_next = '0;
        if (cfg_addr == FIR_REG_CTRL) begin
            rdata_next = 16'(ctrl);
        end
        for (int j = 0; j < `FIR_NUM_TAPS; j++) begin
            if (cfg_addr == cfg_addr_t'(FIR_REG_COEFF0 + j)) begin
                rdata_next = 16'(coeffs[j]);
            end
        end
    end

    always_ff @(posedge clk) begin
        cfg_rdata <= rdata_next;
    end

    a_write_in_map: assert property (
        @(posedge clk) disable iff (rst) cfg_we |-> (cfg_addr <= FIR_REG_COEFF_LAST)
    ) else $error("fir_cfg_regs: write to unmapped address %0d", cfg_addr);

endmodule

// File: design/stream_fifo.sv
// Circular buffer queue with a type-parameterized payload
`timescale 1ns/10ps

module stream_fifo #(
    parameter type payload_t = logic [15:0],
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t pop_data,
    output logic     empty,
    output logic     full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign empty    = (count == '0);
    assign full     = (count == CNT_W'(DEPTH));
    assign pop_data = mem[rd_ptr];

    // Storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // Pointers wrap at DEPTH, which need not be a power of two
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Producers and consumers must respect the credit scheme around this queue
    a_no_overflow: assert property (@(posedge clk) disable iff (rst) !(push && full))
        else $error("stream_fifo: push while full");

    a_no_underflow: assert property (@(posedge clk) disable iff (rst) !(pop && empty))
        else $error("stream_fifo: pop while empty");

endmodule

// File: design/fir_result_if.sv
// Result path between the FIR datapath and the output port
`timescale 1ns/10ps

interface fir_result_if;
    import fir_types_pkg::*;

    // Datapath side
    logic    valid;
    sample_t result;
    logic    sat;

    // One pulse per result leaving the result queue
    logic    free;

    modport src (
        output valid,
        output result,
        output sat,
        input  free
    );

    modport dst (
        input  valid,
        input  result,
        input  sat,
        output free
    );

endinterface

// File: design/fir_regs_pkg.sv
// Register map addresses and control register layout
`include "fir_defines.svh"

package fir_regs_pkg;

    typedef logic [2:0] cfg_addr_t;

    // Register map
    localparam cfg_addr_t FIR_REG_CTRL       = 3'd0;
    localparam cfg_addr_t FIR_REG_COEFF0     = 3'd1;
    localparam cfg_addr_t FIR_REG_COEFF_LAST = cfg_addr_t'(FIR_REG_COEFF0 + `FIR_NUM_TAPS - 1);

    // Control register, shift in bits 4:1 and enable in bit 0
    typedef struct packed {
        logic [3:0] shift;
        logic       enable;
    } ctrl_reg_t;

    localparam ctrl_reg_t CTRL_RESET = '{shift: 4'd0, enable: 1'b1};

endpackage

// File: design/fir_types_pkg.sv
// Sample, coefficient, product, accumulator and result types for the FIR datapath
`include "fir_defines.svh"

package fir_types_pkg;

    // Input and output samples
    typedef logic signed [`FIR_SAMPLE_W-1:0] sample_t;

    typedef logic signed [`FIR_COEFF_W-1:0] coeff_t;

    // One full-precision tap product
    typedef logic signed [`FIR_SAMPLE_W+`FIR_COEFF_W-1:0] prod_t;

    // Sum of all tap products, two guard bits for four taps
    typedef logic signed [`FIR_SAMPLE_W+`FIR_COEFF_W+$clog2(`FIR_NUM_TAPS)-1:0] acc_t;

    // Saturated result as it sits in the result queue
    typedef struct packed {
        sample_t value;
        logic    sat;
    } result_t;

    typedef coeff_t [`FIR_NUM_TAPS-1:0] coeff_array_t;

endpackage

// File: include/fir_defines.svh
// Width, tap count, queue depth, credit and reset seed macros for the FIR subsystem
`ifndef FIR_DEFINES_SVH
`define FIR_DEFINES_SVH

// Datapath widths
`define FIR_SAMPLE_W    16
`define FIR_COEFF_W     16
`define FIR_NUM_TAPS    4

// Queue depths, which double as initial credit counts
`define FIR_IN_DEPTH    4
`define FIR_RES_DEPTH   4
`define FIR_OUT_CREDITS 2

// Coefficient j resets to seed[15:0] + j
`define FIR_COEFF_SEED  64'h1234_5678_9ABC_DEF0

`endif
